/* src.f */
common/sd_pkg.sv
hw/sd_clock_gen.sv
hw/crc7.sv
cmd/sd_cmd_tx.sv
cmd/sd_resp_rx.sv
hw/sd_host_top.sv
dv/sd_host_assert.sv
dv/sd_host_tb.sv

/* Bender.yml */
package:
  name: sd_host

sources:
  # Shared package
  - files:
      - common/sd_pkg.sv

  # Design
  - files:
      - hw/sd_clock_gen.sv
      - hw/crc7.sv
      - cmd/sd_cmd_tx.sv
      - cmd/sd_resp_rx.sv
      - hw/sd_host_top.sv

  # Verification
  - target: test
    files:
      - dv/sd_host_assert.sv
      - dv/sd_host_tb.sv

/* dv/sd_host_tb.sv */
module sd_host_tb
    import sd_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_DIV = 4;
    // Card model behavior
    localparam logic [3:0] SILENT_NIBBLE    = 4'hF;
    localparam logic [3:0] CRC_FAULT_NIBBLE = 4'hE;
    localparam cmd_index_t NO_RESP_INDEX    = 6'd0;
    localparam int GAP_MIN = 2;
    localparam int GAP_MAX = 8;
    // Worst case per transaction covers command, turnaround, full wait and response
    localparam int TXN_CYCLES     = CLK_DIV * (2 * CMD_FRAME_W + RESP_TIMEOUT_BITS + 8);
    localparam int NUM_TXNS       = 30;
    localparam int TIMEOUT_CYCLES = NUM_TXNS * TXN_CYCLES;

    logic       clk_fast;
    logic       init_resetPulse;
    logic       cmd_valid;
    logic       cmd_ready;
    cmd_index_t cmd_index;
    cmd_arg_t   cmd_arg;
    logic       cmd_resp_expected;
    logic       resp_valid;
    frame_t     resp_data;
    logic       resp_crc_err;
    logic       resp_timeout;
    logic       sd_clk;
    wire        sd_cmd;

    logic   card_oe;
    logic   card_out;
    frame_t card_last_frame;
    int     card_cmd_count;
    integer seed;
    int     cycle_count = 0;

    pullup (sd_cmd);
    assign sd_cmd = card_oe ? card_out : 1'bz;

    sd_host_top #(
        .CLK_DIV (CLK_DIV)
    ) sd_host_top_i (
        .clk_fast          (clk_fast),
        .init_resetPulse   (init_resetPulse),
        .cmd_valid         (cmd_valid),
        .cmd_ready         (cmd_ready),
        .cmd_index         (cmd_index),
        .cmd_arg           (cmd_arg),
        .cmd_resp_expected (cmd_resp_expected),
        .resp_valid        (resp_valid),
        .resp_data         (resp_data),
        .resp_crc_err      (resp_crc_err),
        .resp_timeout      (resp_timeout),
        .sd_clk            (sd_clk),
        .sd_cmd            (sd_cmd)
    );

    always #4 clk_fast = ~clk_fast;

    // ============================
    // Failure handling
    // ============================
    task automatic end_with_failure();
        $display("Test failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [47:0] expected,
                               input logic [47:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0d ns: %s expected %h, actual %h",
                     $time, name, expected, actual);
            end_with_failure();
        end
    endtask

    always @(posedge clk_fast) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            end_with_failure();
        end
        if (sd_host_top_i.sd_host_assert_i.violation) begin
            $display("A protocol assertion failed at %0d ns", $time);
            end_with_failure();
        end
    end

    // sd_clk rises once every CLK_DIV cycles, reset included
    initial begin : sd_clk_period
        int last_rise;
        @(posedge sd_clk);
        last_rise = cycle_count;
        forever begin
            @(posedge sd_clk);
            check_value("sd_clk period", 48'(CLK_DIV), 48'(cycle_count - last_rise));
            last_rise = cycle_count;
        end
    end

    // Remainder of the payload times x^7 divided by x^7 + x^3 + 1
    function automatic crc7_t crc7_of(input logic [39:0] bits);
        logic [46:0] rem;
        int i;
        rem = {bits, 7'b0};
        for (i = 46; i >= 7; i--) begin
            if (rem[i]) begin
                rem[i -: 8] = rem[i -: 8] ^ 8'h89;
            end
        end
        return rem[6:0];
    endfunction

    function automatic frame_t expected_response(input cmd_index_t idx, input cmd_arg_t arg);
        logic [39:0] body;
        crc7_t crc;
        body = {1'b0, 1'b0, idx, ~arg};
        crc  = crc7_of(body);
        if (arg[31:28] == CRC_FAULT_NIBBLE) begin
            crc[0] = ~crc[0];
        end
        return {body, crc, 1'b1};
    endfunction

    // ============================
    // Card model
    // ============================
    task automatic send_response(input frame_t rsp);
        int gap;
        int i;
        gap = GAP_MIN + ($unsigned($random(seed)) % (GAP_MAX - GAP_MIN + 1));
        // First falling edge after the end bit is where the host releases the line
        repeat (1 + gap) @(negedge sd_clk);
        for (i = CMD_FRAME_W - 1; i >= 0; i--) begin
            #1;
            card_oe  = 1'b1;
            card_out = rsp[i];
            @(negedge sd_clk);
        end
        #1;
        card_oe  = 1'b0;
        card_out = 1'b1;
    endtask

    initial begin : card_model
        frame_t frame;
        int i;
        card_oe        = 1'b0;
        card_out       = 1'b1;
        card_cmd_count = 0;
        forever begin
            @(posedge sd_clk);
            if (sd_cmd === 1'b0) begin
                frame[CMD_FRAME_W-1] = 1'b0;
                for (i = CMD_FRAME_W - 2; i >= 0; i--) begin
                    @(posedge sd_clk);
                    frame[i] = sd_cmd;
                end
                check_value("cmd direction bit", 48'd1, frame[46]);
                check_value("cmd crc7", crc7_of(frame[47:8]), frame[7:1]);
                check_value("cmd end bit", 48'd1, frame[0]);
                card_last_frame = frame;
                card_cmd_count++;
                if ((frame[45:40] != NO_RESP_INDEX) && (frame[39:36] != SILENT_NIBBLE)) begin
                    send_response(expected_response(frame[45:40], frame[39:8]));
                end
            end
        end
    end

    // ============================
    // Stimulus
    // ============================
    task automatic issue_request(input cmd_index_t idx, input cmd_arg_t arg,
                                 input logic resp_exp);
        while (cmd_ready !== 1'b1) begin
            @(posedge clk_fast);
            #1;
        end
        cmd_valid         = 1'b1;
        cmd_index         = idx;
        cmd_arg           = arg;
        cmd_resp_expected = resp_exp;
        @(posedge clk_fast);
        #1;
        cmd_valid = 1'b0;
        check_value("cmd_ready after acceptance", 48'd0, cmd_ready);
    endtask

    task automatic run_transaction(input cmd_index_t idx, input cmd_arg_t arg,
                                   input logic resp_exp);
        int frames_before;
        frames_before = card_cmd_count;
        issue_request(idx, arg, resp_exp);
        if (resp_exp) begin
            do begin
                @(posedge clk_fast);
                #1;
            end while (resp_valid !== 1'b1);
            if (arg[31:28] == SILENT_NIBBLE) begin
                check_value("resp_data", '1, resp_data);
                check_value("resp_timeout", 48'd1, resp_timeout);
                check_value("resp_crc_err", 48'd0, resp_crc_err);
            end else begin
                check_value("resp_data", expected_response(idx, arg), resp_data);
                check_value("resp_timeout", 48'd0, resp_timeout);
                check_value("resp_crc_err", 48'(arg[31:28] == CRC_FAULT_NIBBLE), resp_crc_err);
            end
        end else begin
            do begin
                @(posedge clk_fast);
                #1;
                check_value("resp_valid", 48'd0, resp_valid);
            end while (cmd_ready !== 1'b1);
        end
        check_value("card frame count", 48'(frames_before + 1), 48'(card_cmd_count));
        check_value("card index and argument", {idx, arg}, card_last_frame[45:8]);
    endtask

    function automatic cmd_index_t random_index();
        cmd_index_t idx;
        idx = cmd_index_t'($random(seed));
        if (idx == NO_RESP_INDEX) begin
            idx = 6'd1;
        end
        return idx;
    endfunction

    function automatic cmd_arg_t plain_arg();
        cmd_arg_t arg;
        arg = $random(seed);
        // Keep clear of the E and F patterns
        if (arg[31:29] == 3'b111) begin
            arg[29] = 1'b0;
        end
        return arg;
    endfunction

    initial begin : stimulus
        int n;
        int kind;
        seed              = 32'h5cc4_5f4a;
        clk_fast          = 1'b0;
        init_resetPulse   = 1'b1;
        cmd_valid         = 1'b0;
        cmd_index         = '0;
        cmd_arg           = '0;
        cmd_resp_expected = 1'b0;
        repeat (10) @(posedge clk_fast);
        #1;
        init_resetPulse = 1'b0;

        check_value("crc7 of CMD0", 48'h4A, crc7_of(40'h40_0000_0000));
        repeat (20) begin
            @(posedge clk_fast);
            #1;
            check_value("cmd_ready after reset", 48'd1, cmd_ready);
            check_value("resp_valid while idle", 48'd0, resp_valid);
        end

        run_transaction(random_index(), plain_arg(), 1'b1);
        run_transaction(NO_RESP_INDEX, $random(seed), 1'b0);
        run_transaction(random_index(), {CRC_FAULT_NIBBLE, 28'($random(seed))}, 1'b1);
        run_transaction(random_index(), {SILENT_NIBBLE, 28'($random(seed))}, 1'b1);

        // Back to back with mixed kinds
        for (n = 0; n < 20; n++) begin
            kind = $unsigned($random(seed)) % 4;
            case (kind)
                0: run_transaction(random_index(), plain_arg(), 1'b1);
                1: run_transaction(NO_RESP_INDEX, $random(seed), 1'b0);
                2: run_transaction(random_index(), {CRC_FAULT_NIBBLE, 28'($random(seed))}, 1'b1);
                default: run_transaction(random_index(), {SILENT_NIBBLE, 28'($random(seed))}, 1'b1);
            endcase
        end

        repeat (4) @(posedge clk_fast);
        if (sd_host_top_i.sd_host_assert_i.violation) begin
            $display("A protocol assertion failed during the run");
            end_with_failure();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

/* dv/sd_host_assert.sv */
module sd_host_assert (
    input logic clk_fast,
    input logic init_resetPulse,
    input logic cmd_valid,
    input logic cmd_ready,
    input logic cmd_resp_expected,
    input logic resp_valid,
    input logic cmd_oe,
    input logic rx_start,
    input logic rx_done
);
    timeunit 1ns;
    timeprecision 100ps;

    logic in_reset_q = 1'b0;
    logic rx_busy;
    logic resp_pending;
    // Watched by the testbench top
    logic violation = 1'b0;

    // ============================
    // Tracking state
    // ============================
    always_ff @(posedge clk_fast) begin
        in_reset_q <= init_resetPulse;
        if (init_resetPulse) begin
            rx_busy      <= 1'b0;
            resp_pending <= 1'b0;
        end else begin
            if (rx_start) begin
                rx_busy <= 1'b1;
            end else if (rx_done) begin
                rx_busy <= 1'b0;
            end
            if (cmd_valid && cmd_ready && cmd_resp_expected) begin
                resp_pending <= 1'b1;
            end else if (resp_valid) begin
                resp_pending <= 1'b0;
            end
        end
    end

    // Line stays released through reset and the cycle after it
    oe_off_in_reset: assert property (@(posedge clk_fast) in_reset_q |-> !cmd_oe)
        else begin
            $error("cmd_oe high during reset or in the cycle after it");
            violation = 1'b1;
        end

    ready_low_until_resp: assert property (@(posedge clk_fast)
        disable iff (init_resetPulse) resp_pending |-> !cmd_ready)
        else begin
            $error("cmd_ready high before the matching resp_valid");
            violation = 1'b1;
        end

    resp_single_cycle: assert property (@(posedge clk_fast)
        disable iff (init_resetPulse) resp_valid |=> !resp_valid)
        else begin
            $error("resp_valid held longer than one cycle");
            violation = 1'b1;
        end

    // Host must not fight the card
    oe_off_while_rx: assert property (@(posedge clk_fast)
        disable iff (init_resetPulse) (rx_start || rx_busy) |-> !cmd_oe)
        else begin
            $error("cmd_oe high while the receiver owns the line");
            violation = 1'b1;
        end

endmodule

bind sd_host_top sd_host_assert sd_host_assert_i (
    .clk_fast          (clk_fast),
    .init_resetPulse   (init_resetPulse),
    .cmd_valid         (cmd_valid),
    .cmd_ready         (cmd_ready),
    .cmd_resp_expected (cmd_resp_expected),
    .resp_valid        (resp_valid),
    .cmd_oe            (cmd_oe),
    .rx_start          (rx_start),
    .rx_done           (rx_done)
);

/* hw/sd_host_top.sv */
module sd_host_top
    import sd_pkg::*;
#(
    parameter int CLK_DIV = 4
) (
    input  logic       clk_fast,
    input  logic       init_resetPulse,

    // Request
    input  logic       cmd_valid,
    output logic       cmd_ready,
    input  cmd_index_t cmd_index,
    input  cmd_arg_t   cmd_arg,
    input  logic       cmd_resp_expected,

    // Response
    output logic       resp_valid,
    output frame_t     resp_data,
    output logic       resp_crc_err,
    output logic       resp_timeout,

    // Card pins
    output logic       sd_clk,
    inout  wire        sd_cmd
);

    logic drive_tick;
    logic sample_tick;
    logic rx_start;
    logic rx_done;
    logic cmd_oe;
    logic cmd_out;

    // ============================
    // Pin: sd_cmd
    // ============================
    assign sd_cmd = cmd_oe ? cmd_out : 1'bz;

    sd_clock_gen #(
        .CLK_DIV (CLK_DIV)
    ) sd_clock_gen_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .sd_clk          (sd_clk),
        .drive_tick      (drive_tick),
        .sample_tick     (sample_tick)
    );

    sd_cmd_tx sd_cmd_tx_i (
        .clk_fast          (clk_fast),
        .init_resetPulse   (init_resetPulse),
        .drive_tick        (drive_tick),
        .cmd_valid         (cmd_valid),
        .cmd_ready         (cmd_ready),
        .cmd_index         (cmd_index),
        .cmd_arg           (cmd_arg),
        .cmd_resp_expected (cmd_resp_expected),
        .rx_done           (rx_done),
        .rx_start          (rx_start),
        .cmd_oe            (cmd_oe),
        .cmd_out           (cmd_out)
    );

    sd_resp_rx sd_resp_rx_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .sample_tick     (sample_tick),
        .rx_start        (rx_start),
        .cmd_in          (sd_cmd),
        .rx_done         (rx_done),
        .resp_valid      (resp_valid),
        .resp_data       (resp_data),
        .resp_crc_err    (resp_crc_err),
        .resp_timeout    (resp_timeout)
    );

endmodule

/* cmd/sd_resp_rx.sv */
module sd_resp_rx
    import sd_pkg::*;
(
    input  logic   clk_fast,
    input  logic   init_resetPulse,
    input  logic   sample_tick,
    input  logic   rx_start,
    input  logic   cmd_in,
    output logic   rx_done,
    output logic   resp_valid,
    output frame_t resp_data,
    output logic   resp_crc_err,
    output logic   resp_timeout
);

    localparam int CNT_MAX = (RESP_TIMEOUT_BITS > CMD_FRAME_W) ? RESP_TIMEOUT_BITS : CMD_FRAME_W;
    localparam int CNT_W   = $clog2(CNT_MAX);
    localparam logic [CNT_W-1:0] TURN_LAST   = CNT_W'(TURNAROUND_BITS - 1);
    localparam logic [CNT_W-1:0] WAIT_LAST   = CNT_W'(RESP_TIMEOUT_BITS - 1);
    localparam logic [CNT_W-1:0] PAYLOAD_CNT = CNT_W'(CMD_PAYLOAD_W);
    localparam logic [CNT_W-1:0] FRAME_LAST  = CNT_W'(CMD_FRAME_W - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_TURN,
        RX_WAIT,
        RX_SHIFT
    } rx_state_t;

    rx_state_t        state;
    logic [CNT_W-1:0] cnt;
    frame_t           shift_q;
    frame_t           shift_nxt;
    crc7_t            crc;
    logic             start_seen;
    logic             shift_en;
    logic             crc_en;
    logic             crc_bad;
    logic             frame_done;
    logic             wait_expired;

    assign start_seen   = (state == RX_WAIT) && sample_tick && !cmd_in;
    assign shift_en     = start_seen || ((state == RX_SHIFT) && sample_tick);
    // Start bit plus the next 39 bits feed the CRC
    assign crc_en       = start_seen || ((state == RX_SHIFT) && sample_tick && (cnt < PAYLOAD_CNT));
    assign frame_done   = (state == RX_SHIFT) && sample_tick && (cnt == FRAME_LAST);
    assign wait_expired = (state == RX_WAIT) && sample_tick && cmd_in && (cnt == WAIT_LAST);

    assign shift_nxt = {shift_q[CMD_FRAME_W-2:0], cmd_in};
    assign crc_bad   = (shift_nxt[FRAME_CRC_MSB:FRAME_CRC_LSB] != crc) ||
                       (shift_nxt[FRAME_END_POS] != END_BIT);

    crc7 crc7_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .clear           (rx_start),
        .shift_en        (crc_en),
        .din             (cmd_in),
        .crc             (crc)
    );

    always_ff @(posedge clk_fast) begin
        if (shift_en) begin
            shift_q <= shift_nxt;
        end
    end

    always_ff @(posedge clk_fast) begin
        if (wait_expired) begin
            resp_data <= '1;
        end else if (frame_done) begin
            resp_data <= shift_nxt;
        end
    end

    // ============================
    // Receive FSM
    // ============================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state        <= RX_IDLE;
            cnt          <= '0;
            rx_done      <= 1'b0;
            resp_valid   <= 1'b0;
            resp_crc_err <= 1'b0;
            resp_timeout <= 1'b0;
        end else begin
            rx_done    <= frame_done || wait_expired;
            resp_valid <= frame_done || wait_expired;
            case (state)
                RX_IDLE: begin
                    if (rx_start) begin
                        cnt   <= '0;
                        state <= RX_TURN;
                    end
                end
                // Line floats on its pull-up while the card takes over
                RX_TURN: begin
                    if (sample_tick) begin
                        if (cnt == TURN_LAST) begin
                            cnt   <= '0;
                            state <= RX_WAIT;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                RX_WAIT: begin
                    if (start_seen) begin
                        cnt   <= CNT_W'(1);
                        state <= RX_SHIFT;
                    end else if (wait_expired) begin
                        resp_timeout <= 1'b1;
                        resp_crc_err <= 1'b0;
                        state        <= RX_IDLE;
                    end else if (sample_tick) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_SHIFT: begin
                    if (frame_done) begin
                        resp_timeout <= 1'b0;
                        resp_crc_err <= crc_bad;
                        state        <= RX_IDLE;
                    end else if (sample_tick) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

/* cmd/sd_cmd_tx.sv */
module sd_cmd_tx
    import sd_pkg::*;
(
    input  logic       clk_fast,
    input  logic       init_resetPulse,
    input  logic       drive_tick,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    input  cmd_index_t cmd_index,
    input  cmd_arg_t   cmd_arg,
    input  logic       cmd_resp_expected,
    input  logic       rx_done,
    output logic       rx_start,
    output logic       cmd_oe,
    output logic       cmd_out
);

    localparam int BIT_CNT_W = $clog2(CMD_FRAME_W + 1);
    localparam int CRC_SEL_W = $clog2(CRC7_W);
    localparam logic [BIT_CNT_W-1:0] PAYLOAD_END = BIT_CNT_W'(CMD_PAYLOAD_W);
    localparam logic [BIT_CNT_W-1:0] CRC_END     = BIT_CNT_W'(CMD_FRAME_W - 1);
    localparam logic [BIT_CNT_W-1:0] CRC_TOP     = BIT_CNT_W'(CMD_FRAME_W - 2);
    localparam logic [BIT_CNT_W-1:0] FRAME_END   = BIT_CNT_W'(CMD_FRAME_W);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SEND,
        TX_WAIT_RX
    } tx_state_t;

    tx_state_t                state;
    logic [CMD_PAYLOAD_W-1:0] payload_q;
    logic [BIT_CNT_W-1:0]     bit_cnt;
    logic [BIT_CNT_W-1:0]     crc_pos;
    logic                     resp_expected_q;
    logic                     accept;
    logic                     payload_shift;
    logic                     next_bit;
    crc7_t                    crc;

    assign cmd_ready     = (state == TX_IDLE);
    assign accept        = cmd_valid && cmd_ready;
    assign payload_shift = (state == TX_SEND) && drive_tick && (bit_cnt < PAYLOAD_END);

    // CRC follows the payload, MSB first
    assign crc_pos = CRC_TOP - bit_cnt;

    always_comb begin
        if (bit_cnt < PAYLOAD_END) begin
            next_bit = payload_q[CMD_PAYLOAD_W-1];
        end else if (bit_cnt < CRC_END) begin
            next_bit = crc[crc_pos[CRC_SEL_W-1:0]];
        end else begin
            next_bit = END_BIT;
        end
    end

    crc7 crc7_i (
        .clk_fast        (clk_fast),
        .init_resetPulse (init_resetPulse),
        .clear           (accept),
        .shift_en        (payload_shift),
        .din             (payload_q[CMD_PAYLOAD_W-1]),
        .crc             (crc)
    );

    always_ff @(posedge clk_fast) begin
        if (accept) begin
            payload_q <= {START_BIT, DIR_HOST, cmd_index, cmd_arg};
        end else if (payload_shift) begin
            payload_q <= {payload_q[CMD_PAYLOAD_W-2:0], 1'b0};
        end
    end

    // ============================
    // Transmit FSM
    // ============================
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            state           <= TX_IDLE;
            bit_cnt         <= '0;
            resp_expected_q <= 1'b0;
            rx_start        <= 1'b0;
            cmd_oe          <= 1'b0;
            cmd_out         <= 1'b1;
        end else begin
            rx_start <= 1'b0;
            case (state)
                TX_IDLE: begin
                    if (accept) begin
                        bit_cnt         <= '0;
                        resp_expected_q <= cmd_resp_expected;
                        state           <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    if (drive_tick) begin
                        if (bit_cnt == FRAME_END) begin
                            // End bit has had its full period, release the line
                            cmd_oe  <= 1'b0;
                            cmd_out <= 1'b1;
                            if (resp_expected_q) begin
                                rx_start <= 1'b1;
                                state    <= TX_WAIT_RX;
                            end else begin
                                state <= TX_IDLE;
                            end
                        end else begin
                            cmd_oe  <= 1'b1;
                            cmd_out <= next_bit;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                TX_WAIT_RX: begin
                    if (rx_done) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

/* hw/crc7.sv */
module crc7
    import sd_pkg::*;
(
    input  logic  clk_fast,
    input  logic  init_resetPulse,
    input  logic  clear,
    input  logic  shift_en,
    input  logic  din,
    output crc7_t crc
);

    // x^7 + x^3 + 1
    localparam crc7_t POLY = 7'h09;

    logic feedback;

    assign feedback = din ^ crc[CRC7_W-1];

    always_ff @(posedge clk_fast) begin
        if (init_resetPulse || clear) begin
            crc <= '0;
        end else if (shift_en) begin
            crc <= {crc[CRC7_W-2:0], 1'b0} ^ (feedback ? POLY : '0);
        end
    end

endmodule

/* hw/sd_clock_gen.sv */
module sd_clock_gen #(
    parameter int CLK_DIV = 4
) (
    input  logic clk_fast,
    input  logic init_resetPulse,
    output logic sd_clk,
    output logic drive_tick,
    output logic sample_tick
);

    localparam int CNT_W = $clog2(CLK_DIV);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_DIV - 1);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLK_DIV / 2);

    if ((CLK_DIV < 2) || ((CLK_DIV % 2) != 0)) begin : g_bad_div
        $error("CLK_DIV must be even and at least 2");
    end

    logic [CNT_W-1:0] div_cnt = '0;
    logic [CNT_W-1:0] div_cnt_nxt;

    assign div_cnt_nxt = (div_cnt == CNT_LAST) ? '0 : div_cnt + 1'b1;

    // Free-running divider, sd_clk high in the second half of the count
    always_ff @(posedge clk_fast) begin
        div_cnt <= div_cnt_nxt;
        sd_clk  <= (div_cnt_nxt >= CNT_HALF);
    end

    // Strobes line up with the sd_clk edges
    always_ff @(posedge clk_fast) begin
        if (init_resetPulse) begin
            drive_tick  <= 1'b0;
            sample_tick <= 1'b0;
        end else begin
            drive_tick  <= (div_cnt_nxt == '0);
            sample_tick <= (div_cnt_nxt == CNT_HALF);
        end
    end

endmodule

/* common/sd_pkg.sv */
package sd_pkg;

    // ============================
    // Frame geometry
    // ============================
    localparam int CMD_FRAME_W   = 48;
    // Start bit, direction bit, index and argument
    localparam int CMD_PAYLOAD_W = 40;
    localparam int CMD_INDEX_W   = 6;
    localparam int CMD_ARG_W     = 32;
    localparam int CRC7_W        = 7;

    // Field positions, bit 47 is first on the line
    localparam int FRAME_CRC_MSB = 7;
    localparam int FRAME_CRC_LSB = 1;
    localparam int FRAME_END_POS = 0;

    // Fixed framing bits
    localparam logic START_BIT = 1'b0;
    localparam logic DIR_HOST  = 1'b1;
    localparam logic END_BIT   = 1'b1;

    // ============================
    // Response timing
    // ============================
    // Counted in sd_clk periods
    localparam int TURNAROUND_BITS   = 2;
    localparam int RESP_TIMEOUT_BITS = 64;

    // ============================
    // Types
    // ============================
    typedef logic [CMD_INDEX_W-1:0] cmd_index_t;
    typedef logic [CMD_ARG_W-1:0]   cmd_arg_t;
    typedef logic [CMD_FRAME_W-1:0] frame_t;
    typedef logic [CRC7_W-1:0]      crc7_t;

endpackage
